// File: burst_params.svh
// bus widths, burst length and memory depth for the AXI4 burst subsystem
`ifndef BURST_PARAMS_SVH
`define BURST_PARAMS_SVH

// data bus width in bits
`define DATA_W 32

// byte address width
`define ADDR_W 32

// beats per INCR burst, 2 to 16
`define BURST_LEN 8

// memory depth in data words
`define MEM_WORDS 64

`endif

// File: burst_pkg.sv
// state and response types shared by the burst master and the burst memory
package burst_pkg;

    // master phases
    typedef enum logic [2:0] {
        MST_IDLE  = 3'd0,
        MST_WADDR = 3'd1,
        MST_WDATA = 3'd2,
        MST_WRESP = 3'd3,
        MST_RADDR = 3'd4,
        MST_RDATA = 3'd5
    } mst_state_e;

    // memory phases
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_WDATA = 2'd1,
        MEM_WRESP = 2'd2,
        MEM_RDATA = 2'd3
    } mem_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

endpackage

// File: axi_burst_if.sv
// AXI4 burst bus, AW W B AR R channels, ID zero only
`timescale 1ns/1ns
`include "burst_params.svh"

interface axi_burst_if;

    // write address
    logic [`ADDR_W-1:0]     awaddr;
    logic [7:0]             awlen;
    logic [2:0]             awsize;
    logic [1:0]             awburst;
    logic                   awvalid;
    logic                   awready;
    // write data
    logic [`DATA_W-1:0]     wdata;
    logic [`DATA_W/8-1:0]   wstrb;
    logic                   wlast;
    logic                   wvalid;
    logic                   wready;
    // write response
    burst_pkg::resp_e       bresp;
    logic                   bvalid;
    logic                   bready;
    // read address
    logic [`ADDR_W-1:0]     araddr;
    logic [7:0]             arlen;
    logic [2:0]             arsize;
    logic [1:0]             arburst;
    logic                   arvalid;
    logic                   arready;
    // read data
    logic [`DATA_W-1:0]     rdata;
    burst_pkg::resp_e       rresp;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;

    modport mst (
        output awaddr, awlen, awsize, awburst, awvalid, input awready,
        output wdata, wstrb, wlast, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arlen, arsize, arburst, arvalid, input arready,
        input rdata, rresp, rlast, rvalid, output rready
    );

    modport slv (
        input awaddr, awlen, awsize, awburst, awvalid, output awready,
        input wdata, wstrb, wlast, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arlen, arsize, arburst, arvalid, output arready,
        output rdata, rresp, rlast, rvalid, input rready
    );

endinterface

// File: axi_burst_master.sv
// AXI4 burst master, runs one INCR burst per user command
// write beats from a valid/ready stream, read beats out on a stream with last
`timescale 1ns/1ns
`include "burst_params.svh"

module axi_burst_master (
    input  logic                clk,
    input  logic                rst,
    // command
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic                cmd_write,
    input  logic [`ADDR_W-1:0]  cmd_addr,
    // write stream
    input  logic [`DATA_W-1:0]  user_wdata,
    input  logic                user_wvalid,
    output logic                user_wready,
    // read stream, no back-pressure
    output logic [`DATA_W-1:0]  user_rdata,
    output logic                user_rvalid,
    output logic                user_rlast,
    // result
    output logic                done,
    output logic                err,
    axi_burst_if.mst            bus
);

    localparam logic [7:0] LEN_M1     = 8'(`BURST_LEN - 1);
    localparam logic [2:0] WORD_SIZE  = 3'($clog2(`DATA_W / 8));
    localparam logic [1:0] BURST_INCR = 2'b01;

    burst_pkg::mst_state_e state;
    logic [`ADDR_W-1:0]    addr_q;
    logic [7:0]            wbeat;     // accepted W beats so far
    logic                  err_q;
    logic                  done_q;
    logic                  cmd_hs;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  b_hs;
    logic                  ar_hs;
    logic                  r_hs;

    assign cmd_hs = cmd_valid && cmd_ready;
    assign aw_hs  = bus.awvalid && bus.awready;
    assign w_hs   = bus.wvalid && bus.wready;
    assign b_hs   = bus.bvalid && bus.bready;
    assign ar_hs  = bus.arvalid && bus.arready;
    assign r_hs   = bus.rvalid && bus.rready;

    assign cmd_ready = (state == burst_pkg::MST_IDLE);

    // address channels, fixed burst shape
    assign bus.awaddr  = addr_q;
    assign bus.awlen   = LEN_M1;
    assign bus.awsize  = WORD_SIZE;
    assign bus.awburst = BURST_INCR;
    assign bus.awvalid = (state == burst_pkg::MST_WADDR);
    assign bus.araddr  = addr_q;
    assign bus.arlen   = LEN_M1;
    assign bus.arsize  = WORD_SIZE;
    assign bus.arburst = BURST_INCR;
    assign bus.arvalid = (state == burst_pkg::MST_RADDR);

    // write data comes straight from the user stream
    assign bus.wdata  = user_wdata;
    assign bus.wstrb  = '1;   // full words only
    assign bus.wvalid = (state == burst_pkg::MST_WDATA) && user_wvalid;
    assign bus.wlast  = bus.wvalid && (wbeat == LEN_M1);
    assign user_wready = (state == burst_pkg::MST_WDATA) && bus.wready;

    assign bus.bready = (state == burst_pkg::MST_WRESP);
    assign bus.rready = (state == burst_pkg::MST_RDATA);

    // read beats pass through in the handshake cycle
    assign user_rdata  = bus.rdata;
    assign user_rvalid = r_hs;
    assign user_rlast  = r_hs && bus.rlast;

    assign done = done_q;
    assign err  = err_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= burst_pkg::MST_IDLE;
            wbeat  <= 8'd0;
            err_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= b_hs || (r_hs && bus.rlast);
            case (state)
                burst_pkg::MST_IDLE: begin
                    if (cmd_hs) begin
                        state <= cmd_write ? burst_pkg::MST_WADDR : burst_pkg::MST_RADDR;
                        wbeat <= 8'd0;
                        err_q <= 1'b0;
                    end
                end
                burst_pkg::MST_WADDR: if (aw_hs) state <= burst_pkg::MST_WDATA;
                burst_pkg::MST_WDATA: begin
                    if (w_hs) begin
                        wbeat <= wbeat + 8'd1;
                        if (bus.wlast) state <= burst_pkg::MST_WRESP;
                    end
                end
                burst_pkg::MST_WRESP: begin
                    if (b_hs) begin
                        err_q <= (bus.bresp == burst_pkg::RESP_SLVERR);
                        state <= burst_pkg::MST_IDLE;
                    end
                end
                burst_pkg::MST_RADDR: if (ar_hs) state <= burst_pkg::MST_RDATA;
                burst_pkg::MST_RDATA: begin
                    if (r_hs) begin
                        // any bad beat flags the whole burst
                        if (bus.rresp == burst_pkg::RESP_SLVERR) err_q <= 1'b1;
                        if (bus.rlast) state <= burst_pkg::MST_IDLE;
                    end
                end
                default: state <= burst_pkg::MST_IDLE;
            endcase
        end
    end

    // start address, held through the burst
    always_ff @(posedge clk) begin
        if (cmd_hs) addr_q <= cmd_addr;
    end

endmodule

// File: axi_burst_mem.sv
// AXI4 slave word memory with INCR burst address counting
// bursts past the end of memory, or of an unsupported shape, get SLVERR
`timescale 1ns/1ns
`include "burst_params.svh"

module axi_burst_mem (
    input  logic        clk,
    input  logic        rst,
    axi_burst_if.slv    bus
);

    localparam int               IDX_W      = $clog2(`MEM_WORDS);
    localparam int               BYTE_SH    = $clog2(`DATA_W / 8);
    localparam int               NBYTES     = `DATA_W / 8;
    localparam int               AW1        = `ADDR_W + 1;
    localparam logic [2:0]       WORD_SIZE  = 3'(BYTE_SH);
    localparam logic [1:0]       BURST_INCR = 2'b01;
    localparam logic [`ADDR_W:0] DEPTH      = `MEM_WORDS;

    burst_pkg::mem_state_e state;
    burst_pkg::resp_e      resp;
    logic [`DATA_W-1:0]    mem [`MEM_WORDS];
    logic [IDX_W-1:0]      widx;      // current word
    logic [7:0]            rbeat;
    logic [7:0]            rlen_q;
    logic                  bad_q;     // range or shape failure of this burst
    logic                  aw_hs;
    logic                  w_hs;
    logic                  b_hs;
    logic                  ar_hs;
    logic                  r_hs;

    // true when the burst cannot be served
    function automatic logic burst_bad(input logic [`ADDR_W-1:0] addr,
                                       input logic [7:0]         len,
                                       input logic [2:0]         size,
                                       input logic [1:0]         burst);
        logic [`ADDR_W:0] end_idx;
        end_idx = {1'b0, addr >> BYTE_SH} + AW1'(len) + AW1'(1);
        return (end_idx > DEPTH) || (size != WORD_SIZE) || (burst != BURST_INCR);
    endfunction

    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign b_hs  = bus.bvalid && bus.bready;
    assign ar_hs = bus.arvalid && bus.arready;
    assign r_hs  = bus.rvalid && bus.rready;

    assign resp = bad_q ? burst_pkg::RESP_SLVERR : burst_pkg::RESP_OKAY;

    // both address channels open in idle, the master never drives both
    assign bus.awready = (state == burst_pkg::MEM_IDLE);
    assign bus.arready = (state == burst_pkg::MEM_IDLE);
    assign bus.wready  = (state == burst_pkg::MEM_WDATA);
    assign bus.bvalid  = (state == burst_pkg::MEM_WRESP);
    assign bus.bresp   = resp;
    assign bus.rvalid  = (state == burst_pkg::MEM_RDATA);
    assign bus.rdata   = bad_q ? '0 : mem[widx];
    assign bus.rresp   = resp;
    assign bus.rlast   = bus.rvalid && (rbeat == rlen_q);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= burst_pkg::MEM_IDLE;
            widx   <= '0;
            rbeat  <= 8'd0;
            rlen_q <= 8'd0;
            bad_q  <= 1'b0;
        end else begin
            case (state)
                burst_pkg::MEM_IDLE: begin
                    if (aw_hs) begin   // write wins a tie
                        widx  <= IDX_W'(bus.awaddr >> BYTE_SH);
                        bad_q <= burst_bad(bus.awaddr, bus.awlen, bus.awsize, bus.awburst);
                        state <= burst_pkg::MEM_WDATA;
                    end else if (ar_hs) begin
                        widx   <= IDX_W'(bus.araddr >> BYTE_SH);
                        bad_q  <= burst_bad(bus.araddr, bus.arlen, bus.arsize, bus.arburst);
                        rbeat  <= 8'd0;
                        rlen_q <= bus.arlen;
                        state  <= burst_pkg::MEM_RDATA;
                    end
                end
                burst_pkg::MEM_WDATA: begin
                    if (w_hs) begin
                        widx <= widx + 1'b1;
                        if (bus.wlast) state <= burst_pkg::MEM_WRESP;
                    end
                end
                burst_pkg::MEM_WRESP: if (b_hs) state <= burst_pkg::MEM_IDLE;
                burst_pkg::MEM_RDATA: begin
                    if (r_hs) begin
                        widx  <= widx + 1'b1;
                        rbeat <= rbeat + 8'd1;
                        if (bus.rlast) state <= burst_pkg::MEM_IDLE;
                    end
                end
                default: state <= burst_pkg::MEM_IDLE;
            endcase
        end
    end

    // byte lanes follow wstrb, bad bursts store nothing
    always_ff @(posedge clk) begin
        if (w_hs && !bad_q) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (bus.wstrb[b]) mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: burst_sys.sv
// burst subsystem top, master and slave memory joined by one AXI4 bus
`timescale 1ns/1ns
`include "burst_params.svh"

module burst_sys (
    input  logic                clk,
    input  logic                rst,
    // command
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic                cmd_write,
    input  logic [`ADDR_W-1:0]  cmd_addr,
    // write stream
    input  logic [`DATA_W-1:0]  user_wdata,
    input  logic                user_wvalid,
    output logic                user_wready,
    // read stream
    output logic [`DATA_W-1:0]  user_rdata,
    output logic                user_rvalid,
    output logic                user_rlast,
    // result
    output logic                done,
    output logic                err
);

    axi_burst_if bus_if ();

    axi_burst_master master_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .user_wdata  (user_wdata),
        .user_wvalid (user_wvalid),
        .user_wready (user_wready),
        .user_rdata  (user_rdata),
        .user_rvalid (user_rvalid),
        .user_rlast  (user_rlast),
        .done        (done),
        .err         (err),
        .bus         (bus_if)
    );

    axi_burst_mem mem_i (
        .clk (clk),
        .rst (rst),
        .bus (bus_if)
    );

endmodule

// File: burst_sys_asserts.sv
// AXI handshake, last flag and completion checks bound into burst_sys
`timescale 1ns/1ns
`include "burst_params.svh"

module burst_sys_asserts (
    input logic clk,
    input logic rst,
    input logic awvalid, awready, arvalid, arready,
    input logic wvalid, wready, wlast, bvalid,
    input logic cmd_ready, done
);

    localparam logic [7:0] LAST_BEAT = 8'(`BURST_LEN - 1);

    int         fail_count = 0;   // failed checks so far
    logic [7:0] wcount;           // W beats taken in this burst

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wcount <= 8'd0;
        end else if (wvalid && wready) begin
            wcount <= wlast ? 8'd0 : wcount + 8'd1;
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid) else begin
        fail_count++;
        $error("awvalid dropped before awready");
    end
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid) else begin
        fail_count++;
        $error("arvalid dropped before arready");
    end
    // last flag only with wvalid, and exactly on the final beat
    a_wlast: assert property (@(posedge clk) disable iff (!rst)
        (wlast || wvalid) |-> wvalid && (wlast == (wcount == LAST_BEAT))) else begin
        fail_count++;
        $error("wlast missing, early or high without wvalid");
    end
    a_done: assert property (@(posedge clk) disable iff (!rst) done |-> cmd_ready) else begin
        fail_count++;
        $error("done high while the master is busy");
    end
    // write response only after the last beat was taken
    a_bvalid: assert property (@(posedge clk) disable iff (!rst)
        $rose(bvalid) |-> $past(wvalid && wready && wlast)) else begin
        fail_count++;
        $error("bvalid rose without a wlast handshake");
    end

endmodule

// File: burst_sys_tb.sv
// burst_sys testbench with clock, reset, LFSR stimulus, reference memory model,
// a compare process for read beats and results, and a cycle timeout
`timescale 1ns/1ns
`include "burst_params.svh"

module burst_sys_tb;

    localparam int TIMEOUT = 20 * 18 * `BURST_LEN + 10;   // 18 bursts over all tests plus reset

    logic               clk = 1'b0;
    logic               rst = 1'b0;
    logic               cmd_valid = 1'b0;
    logic               cmd_write = 1'b0;
    logic [`ADDR_W-1:0] cmd_addr = '0;
    logic [`DATA_W-1:0] user_wdata = '0;
    logic               user_wvalid = 1'b0;
    logic               cmd_ready;
    logic               user_wready;
    logic               user_rvalid;
    logic               user_rlast;
    logic               done;
    logic               err;
    logic [`DATA_W-1:0] user_rdata;
    logic [31:0]        lfsr = 32'hd99;
    logic [`DATA_W-1:0] model [`MEM_WORDS];   // what the memory should hold
    logic [`DATA_W-1:0] exp_data [$];
    logic               exp_last [$];
    logic               exp_err [$];
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 marked = 0;          // error count at the end of the last test
    int                 wbeats = 0;
    int                 cycles = 0;

    burst_sys burst_sys_i (.*);

    bind burst_sys burst_sys_asserts asserts_i (
        .clk(clk), .rst(rst), .cmd_ready(cmd_ready), .done(done),
        .awvalid(bus_if.awvalid), .awready(bus_if.awready),
        .arvalid(bus_if.arvalid), .arready(bus_if.arready),
        .wvalid(bus_if.wvalid), .wready(bus_if.wready),
        .wlast(bus_if.wlast), .bvalid(bus_if.bvalid)
    );

    always #5 clk = ~clk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
    endfunction

    function automatic logic out_of_range(input int idx);
        return idx + `BURST_LEN > `MEM_WORDS;
    endfunction

    // expected read word is zero for a burst past the end of memory
    function automatic logic [`DATA_W-1:0] expected_word(input int idx, input int beat);
        return out_of_range(idx) ? '0 : model[idx + beat];
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - marked);
        marked = errors;
    endtask

    // runs one command with write beats from the LFSR and returns after done
    task automatic run_burst(input logic write, input int idx, input logic gaps);
        logic [31:0] data;
        logic [31:0] gap;
        exp_err.push_back(out_of_range(idx));
        for (int b = 0; b < `BURST_LEN && !write; b++) begin
            exp_data.push_back(expected_word(idx, b));
            exp_last.push_back(b == `BURST_LEN - 1);
        end
        wbeats = 0;
        cmd_valid = 1'b1;
        cmd_write = write;
        cmd_addr = `ADDR_W'(idx * 4);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1 cmd_valid = 1'b0;
        for (int b = 0; b < `BURST_LEN && write; b++) begin
            take_bits(`DATA_W, data);
            take_bits(2, gap);
            user_wvalid = 1'b0;
            if (gaps) #(10 * gap);   // idle cycles on the write stream
            user_wdata = data;
            user_wvalid = 1'b1;
            @(negedge clk);
            while (!user_wready) @(negedge clk);
            @(posedge clk);
            #1;
            if (!out_of_range(idx)) model[idx + b] = data;
        end
        // a spare word stays offered until done and must not be taken
        take_bits(`DATA_W, data);
        user_wdata = data;
        user_wvalid = write;
        @(negedge clk);
        while (!done) @(negedge clk);
        @(posedge clk);
        #1;
        user_wvalid = 1'b0;
        if (write) compare("write beats", wbeats, `BURST_LEN);
        compare("pending read beats", exp_data.size(), 0);
    endtask

    // read beats and results checked against the model at mid-cycle
    always @(negedge clk) begin
        if ((user_rvalid && exp_data.size() == 0) || (done && exp_err.size() == 0)) begin
            errors++;
            $display("read beat or done seen with no command pending");
        end else begin
            if (user_rvalid) begin
                compare("user_rdata", user_rdata, exp_data.pop_front());
                compare("user_rlast", 32'(user_rlast), 32'(exp_last.pop_front()));
            end
            if (done) compare("err", 32'(err), 32'(exp_err.pop_front()));
        end
        if (user_wvalid && user_wready) wbeats++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("run timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) model[i] = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        compare("cmd_ready", 32'(cmd_ready), 1);
        compare("done", 32'(done), 0);
        compare("err", 32'(err), 0);
        compare("user_rvalid", 32'(user_rvalid), 0);
        finish_test("reset state");
        @(posedge clk);
        #1;
        run_burst(1'b1, 0, 1'b0);
        run_burst(1'b0, 0, 1'b0);
        finish_test("write then read at word 0");
        run_burst(1'b1, 5, 1'b0);
        run_burst(1'b1, 12, 1'b0);   // overlaps word 12
        run_burst(1'b1, 40, 1'b0);
        run_burst(1'b1, 56, 1'b0);   // ends on the last word
        run_burst(1'b0, 3, 1'b0);
        run_burst(1'b0, 5, 1'b0);
        run_burst(1'b0, 12, 1'b0);
        run_burst(1'b0, 40, 1'b0);
        run_burst(1'b0, 56, 1'b0);
        finish_test("in-range bursts with overlap");
        run_burst(1'b1, 20, 1'b1);
        run_burst(1'b0, 18, 1'b0);
        run_burst(1'b0, 20, 1'b0);
        finish_test("write stream with gaps");
        run_burst(1'b1, 60, 1'b0);
        run_burst(1'b1, 57, 1'b1);
        run_burst(1'b0, 60, 1'b0);
        run_burst(1'b0, 56, 1'b0);   // untouched by the two bad writes
        finish_test("bursts past the end of memory");
        errors += burst_sys_i.asserts_i.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: burst_sys.f
+incdir+.
burst_pkg.sv
axi_burst_if.sv
axi_burst_master.sv
axi_burst_mem.sv
burst_sys.sv
burst_sys_asserts.sv
burst_sys_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, pass only when the pass line shows up
verilator --binary --timing --assert --top-module burst_sys_tb -f burst_sys.f -o burst_sys_sim \
    && ./obj_dir/burst_sys_sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
